// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

  // Architectural register file size
  localparam int NUM_ARCH = 8;
  localparam int ARCH_W   = $clog2(NUM_ARCH);

  // Immediate field width, sign-extended at the station
  localparam int IMM_W = 8;

  // Opcodes carried from dispatch to the ALU
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_ADDI = 3'd3,  // src1 + sext(imm), src2 ignored
    OP_MUL  = 3'd4
  } op_t;

  // Functional unit class, fixed per station entry
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_t;

endpackage

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ns

module rename_stage import ooo_pkg::*; #(
  parameter int NUM_PR = 32
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_valid,
  input  op_t                       dispatch_op,
  input  logic [ARCH_W-1:0]         dispatch_dest,
  input  logic [ARCH_W-1:0]         dispatch_src1,
  input  logic [ARCH_W-1:0]         dispatch_src2,
  input  logic [IMM_W-1:0]          dispatch_imm,
  input  logic                      rs_accept,
  input  logic [ARCH_W-1:0]         arch_rd_idx,
  output logic                      dispatch_ready,
  output logic                      ren_valid,
  output op_t                       ren_op,
  output fu_t                       ren_fu,
  output logic [$clog2(NUM_PR)-1:0] ren_dest_tag,
  output logic [$clog2(NUM_PR)-1:0] ren_src1_tag,
  output logic [$clog2(NUM_PR)-1:0] ren_src2_tag,
  output logic [IMM_W-1:0]          ren_imm,
  output logic [$clog2(NUM_PR)-1:0] arch_map_tag
);

  localparam int TAG_W = $clog2(NUM_PR);

  logic [TAG_W-1:0] map_table [NUM_ARCH];  // Arch reg to newest tag
  logic [TAG_W:0]   alloc_ptr;             // One extra bit to reach NUM_PR
  logic             ren_leave;
  logic             dispatch_fire;

  assign ren_leave      = ren_valid && rs_accept;
  assign dispatch_ready = (!ren_valid || ren_leave) &&
                          (alloc_ptr < (TAG_W+1)'(NUM_PR));
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  assign ren_fu       = (ren_op == OP_MUL) ? FU_MUL : FU_ALU;  // Class from opcode
  assign arch_map_tag = map_table[arch_rd_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      ren_valid <= 1'b0;
      alloc_ptr <= (TAG_W+1)'(NUM_ARCH);  // Tags below NUM_ARCH hold the initial state
      for (int i = 0; i < NUM_ARCH; i++) begin
        map_table[i] <= TAG_W'(i);  // Identity map
      end
    end else begin
      if (dispatch_fire) begin
        ren_valid                <= 1'b1;
        alloc_ptr                <= alloc_ptr + 1'b1;
        map_table[dispatch_dest] <= alloc_ptr[TAG_W-1:0];
      end else if (ren_leave) begin
        ren_valid <= 1'b0;
      end
    end
  end

  // Sources read the map before this instruction's own update
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      ren_op       <= dispatch_op;
      ren_dest_tag <= alloc_ptr[TAG_W-1:0];
      ren_src1_tag <= map_table[dispatch_src1];
      ren_src2_tag <= map_table[dispatch_src2];
      ren_imm      <= dispatch_imm;
    end
  end

endmodule

// ==== hdl/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile import ooo_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int NUM_PR     = 32
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alloc_valid,
  input  logic [$clog2(NUM_PR)-1:0] alloc_tag,
  input  logic [$clog2(NUM_PR)-1:0] src1_tag,
  input  logic [$clog2(NUM_PR)-1:0] src2_tag,
  input  logic                      cdb_valid,
  input  logic [$clog2(NUM_PR)-1:0] cdb_tag,
  input  logic [DATA_WIDTH-1:0]     cdb_value,
  input  logic [$clog2(NUM_PR)-1:0] arch_rd_tag,
  output logic [DATA_WIDTH-1:0]     src1_value,
  output logic                      src1_ready,
  output logic [DATA_WIDTH-1:0]     src2_value,
  output logic                      src2_ready,
  output logic [DATA_WIDTH-1:0]     arch_rd_value,
  output logic                      arch_rd_ready
);

  logic [DATA_WIDTH-1:0] prf_value [NUM_PR];
  logic [NUM_PR-1:0]     prf_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PR; i++) begin
        prf_ready[i] <= (i < NUM_ARCH);  // Only the initial arch copies are valid
        if (i < NUM_ARCH) begin
          prf_value[i] <= '0;
        end
      end
    end else begin
      if (alloc_valid) begin
        prf_ready[alloc_tag] <= 1'b0;  // Pending until its result completes
      end
      if (cdb_valid) begin
        prf_ready[cdb_tag] <= 1'b1;
        prf_value[cdb_tag] <= cdb_value;
      end
    end
  end

  // Operand lookup for the instruction sitting in rename
  assign src1_value = prf_value[src1_tag];
  assign src1_ready = prf_ready[src1_tag];
  assign src2_value = prf_value[src2_tag];
  assign src2_ready = prf_ready[src2_tag];

  assign arch_rd_value = prf_value[arch_rd_tag];
  assign arch_rd_ready = prf_ready[arch_rd_tag];

endmodule

// ==== hdl/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station import ooo_pkg::*; #(
  parameter int DATA_WIDTH  = 16,
  parameter int NUM_PR      = 32,
  parameter int NUM_ALU_RS  = 3,
  parameter int NUM_MUL_RS  = 2,
  parameter int MUL_LATENCY = 3
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ren_valid,
  input  op_t                       ren_op,
  input  fu_t                       ren_fu,
  input  logic [$clog2(NUM_PR)-1:0] ren_dest_tag,
  input  logic [$clog2(NUM_PR)-1:0] ren_src1_tag,
  input  logic [$clog2(NUM_PR)-1:0] ren_src2_tag,
  input  logic [IMM_W-1:0]          ren_imm,
  input  logic [DATA_WIDTH-1:0]     src1_value,
  input  logic                      src1_ready,
  input  logic [DATA_WIDTH-1:0]     src2_value,
  input  logic                      src2_ready,
  input  logic                      cdb_valid,
  input  logic [$clog2(NUM_PR)-1:0] cdb_tag,
  input  logic [DATA_WIDTH-1:0]     cdb_value,
  output logic                      rs_accept,
  output logic                      alu_issue,
  output op_t                       alu_op,
  output logic [DATA_WIDTH-1:0]     alu_a,
  output logic [DATA_WIDTH-1:0]     alu_b,
  output logic [$clog2(NUM_PR)-1:0] alu_tag,
  output logic                      mul_issue,
  output logic [DATA_WIDTH-1:0]     mul_a,
  output logic [DATA_WIDTH-1:0]     mul_b,
  output logic [$clog2(NUM_PR)-1:0] mul_tag,
  output logic                      rs_busy
);

  localparam int TAG_W  = $clog2(NUM_PR);
  localparam int NUM_RS = NUM_ALU_RS + NUM_MUL_RS;  // ALU entries first, then MUL
  localparam int IDX_W  = $clog2(NUM_RS);

  logic [NUM_RS-1:0]     ent_busy;
  logic [NUM_RS-1:0]     ent_rdy1;
  logic [NUM_RS-1:0]     ent_rdy2;
  logic [NUM_RS-1:0]     ent_ready;
  op_t                   ent_op   [NUM_RS];
  logic [TAG_W-1:0]      ent_dest [NUM_RS];
  logic [TAG_W-1:0]      ent_tag1 [NUM_RS];
  logic [TAG_W-1:0]      ent_tag2 [NUM_RS];
  logic [DATA_WIDTH-1:0] ent_val1 [NUM_RS];
  logic [DATA_WIDTH-1:0] ent_val2 [NUM_RS];

  logic                  ins_hit;
  logic [IDX_W-1:0]      ins_idx;
  logic                  insert;
  logic                  ins_cdb1;
  logic                  ins_cdb2;
  logic                  ins_rdy1;
  logic                  ins_rdy2;
  logic [DATA_WIDTH-1:0] ins_val1;
  logic [DATA_WIDTH-1:0] ins_val2;

  logic                  alu_hit;
  logic [IDX_W-1:0]      alu_idx;
  logic                  mul_hit;
  logic [IDX_W-1:0]      mul_idx;
  logic [MUL_LATENCY-2:0] mul_pend;  // Bit k set: multiply issued k+1 edges ago
  logic                  alu_block;

  // Lowest free entry of the incoming class
  always_comb begin
    ins_hit = 1'b0;
    ins_idx = '0;
    for (int i = 0; i < NUM_RS; i++) begin
      if (!ins_hit && !ent_busy[i] && ((i >= NUM_ALU_RS) == (ren_fu == FU_MUL))) begin
        ins_hit = 1'b1;
        ins_idx = IDX_W'(i);
      end
    end
  end

  assign rs_accept = ins_hit;
  assign insert    = ren_valid && ins_hit;

  // Register file is written only at the edge, so catch the CDB here too
  assign ins_cdb1 = cdb_valid && (cdb_tag == ren_src1_tag);
  assign ins_cdb2 = cdb_valid && (cdb_tag == ren_src2_tag);
  assign ins_rdy1 = src1_ready || ins_cdb1;
  assign ins_val1 = ins_cdb1 ? cdb_value : src1_value;
  assign ins_rdy2 = (ren_op == OP_ADDI) || src2_ready || ins_cdb2;
  assign ins_val2 = (ren_op == OP_ADDI) ? {{(DATA_WIDTH-IMM_W){ren_imm[IMM_W-1]}}, ren_imm} :
                    ins_cdb2            ? cdb_value : src2_value;

  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      ent_ready[i] = ent_busy[i] && ent_rdy1[i] && ent_rdy2[i];
    end
  end

  // Oldest-index ready entry per class
  always_comb begin
    alu_hit = 1'b0;
    alu_idx = '0;
    mul_hit = 1'b0;
    mul_idx = IDX_W'(NUM_ALU_RS);
    for (int i = 0; i < NUM_ALU_RS; i++) begin
      if (!alu_hit && ent_ready[i]) begin
        alu_hit = 1'b1;
        alu_idx = IDX_W'(i);
      end
    end
    for (int i = NUM_ALU_RS; i < NUM_RS; i++) begin
      if (!mul_hit && ent_ready[i]) begin
        mul_hit = 1'b1;
        mul_idx = IDX_W'(i);
      end
    end
  end

  // An ALU issued now would share the CDB cycle with this multiply
  assign alu_block = mul_pend[MUL_LATENCY-2];
  assign alu_issue = alu_hit && !alu_block;
  assign mul_issue = mul_hit;

  assign alu_op  = ent_op[alu_idx];
  assign alu_a   = ent_val1[alu_idx];
  assign alu_b   = ent_val2[alu_idx];
  assign alu_tag = ent_dest[alu_idx];
  assign mul_a   = ent_val1[mul_idx];
  assign mul_b   = ent_val2[mul_idx];
  assign mul_tag = ent_dest[mul_idx];

  assign rs_busy = |ent_busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_busy <= '0;
      mul_pend <= '0;
    end else begin
      if (alu_issue) ent_busy[alu_idx] <= 1'b0;
      if (mul_issue) ent_busy[mul_idx] <= 1'b0;
      if (insert)    ent_busy[ins_idx] <= 1'b1;  // Target was free, no clash
      mul_pend[0] <= mul_issue;
      for (int k = 1; k < MUL_LATENCY - 1; k++) begin
        mul_pend[k] <= mul_pend[k-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_RS; i++) begin
      if (ent_busy[i] && cdb_valid && !ent_rdy1[i] && ent_tag1[i] == cdb_tag) begin
        ent_rdy1[i] <= 1'b1;  // Wakeup from CDB
        ent_val1[i] <= cdb_value;
      end
      if (ent_busy[i] && cdb_valid && !ent_rdy2[i] && ent_tag2[i] == cdb_tag) begin
        ent_rdy2[i] <= 1'b1;
        ent_val2[i] <= cdb_value;
      end
    end
    if (insert) begin
      ent_op[ins_idx]   <= ren_op;
      ent_dest[ins_idx] <= ren_dest_tag;
      ent_tag1[ins_idx] <= ren_src1_tag;
      ent_tag2[ins_idx] <= ren_src2_tag;
      ent_rdy1[ins_idx] <= ins_rdy1;
      ent_rdy2[ins_idx] <= ins_rdy2;
      ent_val1[ins_idx] <= ins_val1;
      ent_val2[ins_idx] <= ins_val2;
    end
  end

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import ooo_pkg::*; #(
  parameter int DATA_WIDTH  = 16,
  parameter int NUM_PR      = 32,
  parameter int MUL_LATENCY = 3
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alu_issue,
  input  op_t                       alu_op,
  input  logic [DATA_WIDTH-1:0]     alu_a,
  input  logic [DATA_WIDTH-1:0]     alu_b,
  input  logic [$clog2(NUM_PR)-1:0] alu_tag,
  input  logic                      mul_issue,
  input  logic [DATA_WIDTH-1:0]     mul_a,
  input  logic [DATA_WIDTH-1:0]     mul_b,
  input  logic [$clog2(NUM_PR)-1:0] mul_tag,
  output logic                      cdb_valid,
  output logic [$clog2(NUM_PR)-1:0] cdb_tag,
  output logic [DATA_WIDTH-1:0]     cdb_value,
  output logic                      exec_busy
);

  localparam int TAG_W = $clog2(NUM_PR);

  logic [DATA_WIDTH-1:0]   alu_result;
  logic [2*DATA_WIDTH-1:0] mul_product;
  logic                    alu_valid_q;
  logic [TAG_W-1:0]        alu_tag_q;
  logic [DATA_WIDTH-1:0]   alu_value_q;
  logic [MUL_LATENCY-1:0]  mul_valid_q;
  logic [TAG_W-1:0]        mul_tag_q   [MUL_LATENCY];
  logic [DATA_WIDTH-1:0]   mul_value_q [MUL_LATENCY];

  always_comb begin
    case (alu_op)
      OP_SUB:  alu_result = alu_a - alu_b;
      OP_AND:  alu_result = alu_a & alu_b;
      default: alu_result = alu_a + alu_b;  // ADD and ADDI
    endcase
  end

  assign mul_product = {{DATA_WIDTH{1'b0}}, mul_a} * {{DATA_WIDTH{1'b0}}, mul_b};

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_valid_q <= 1'b0;
      mul_valid_q <= '0;
    end else begin
      alu_valid_q    <= alu_issue;
      mul_valid_q[0] <= mul_issue;
      for (int k = 1; k < MUL_LATENCY; k++) begin
        mul_valid_q[k] <= mul_valid_q[k-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alu_issue) begin
      alu_tag_q   <= alu_tag;
      alu_value_q <= alu_result;
    end
    mul_tag_q[0]   <= mul_tag;
    mul_value_q[0] <= mul_product[DATA_WIDTH-1:0];  // Low half only
    for (int k = 1; k < MUL_LATENCY; k++) begin
      mul_tag_q[k]   <= mul_tag_q[k-1];
      mul_value_q[k] <= mul_value_q[k-1];
    end
  end

  // Station keeps the two sources from landing in the same cycle
  assign cdb_valid = alu_valid_q || mul_valid_q[MUL_LATENCY-1];
  assign cdb_tag   = mul_valid_q[MUL_LATENCY-1] ? mul_tag_q[MUL_LATENCY-1] : alu_tag_q;
  assign cdb_value = mul_valid_q[MUL_LATENCY-1] ? mul_value_q[MUL_LATENCY-1] : alu_value_q;
  assign exec_busy = alu_valid_q || (|mul_valid_q);

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; #(
  parameter int DATA_WIDTH  = 16,
  parameter int NUM_PR      = 32,
  parameter int NUM_ALU_RS  = 3,
  parameter int NUM_MUL_RS  = 2,
  parameter int MUL_LATENCY = 3
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  op_t                   dispatch_op,
  input  logic [ARCH_W-1:0]     dispatch_dest,
  input  logic [ARCH_W-1:0]     dispatch_src1,
  input  logic [ARCH_W-1:0]     dispatch_src2,
  input  logic [IMM_W-1:0]      dispatch_imm,
  input  logic [ARCH_W-1:0]     arch_rd_idx,
  output logic                  dispatch_ready,
  output logic [DATA_WIDTH-1:0] arch_rd_value,
  output logic                  arch_rd_ready,
  output logic                  busy
);

  localparam int TAG_W = $clog2(NUM_PR);

  logic                  ren_valid;
  op_t                   ren_op;
  fu_t                   ren_fu;
  logic [TAG_W-1:0]      ren_dest_tag;
  logic [TAG_W-1:0]      ren_src1_tag;
  logic [TAG_W-1:0]      ren_src2_tag;
  logic [IMM_W-1:0]      ren_imm;
  logic [TAG_W-1:0]      arch_map_tag;
  logic                  rs_accept;
  logic                  rs_busy;
  logic [DATA_WIDTH-1:0] src1_value;
  logic                  src1_ready;
  logic [DATA_WIDTH-1:0] src2_value;
  logic                  src2_ready;
  logic                  alu_issue;
  op_t                   alu_op;
  logic [DATA_WIDTH-1:0] alu_a;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [TAG_W-1:0]      alu_tag;
  logic                  mul_issue;
  logic [DATA_WIDTH-1:0] mul_a;
  logic [DATA_WIDTH-1:0] mul_b;
  logic [TAG_W-1:0]      mul_tag;
  logic                  cdb_valid;
  logic [TAG_W-1:0]      cdb_tag;
  logic [DATA_WIDTH-1:0] cdb_value;
  logic                  exec_busy;

  rename_stage #(.NUM_PR(NUM_PR)) u_rename (
    .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_imm, .rs_accept, .arch_rd_idx,
    .dispatch_ready, .ren_valid, .ren_op, .ren_fu, .ren_dest_tag,
    .ren_src1_tag, .ren_src2_tag, .ren_imm, .arch_map_tag
  );

  phys_regfile #(.DATA_WIDTH(DATA_WIDTH), .NUM_PR(NUM_PR)) u_prf (
    .clock, .reset,
    .alloc_valid (ren_valid && rs_accept),  // Tag goes pending at insertion
    .alloc_tag   (ren_dest_tag),
    .src1_tag    (ren_src1_tag),
    .src2_tag    (ren_src2_tag),
    .cdb_valid, .cdb_tag, .cdb_value,
    .arch_rd_tag (arch_map_tag),
    .src1_value, .src1_ready, .src2_value, .src2_ready,
    .arch_rd_value, .arch_rd_ready
  );

  reservation_station #(
    .DATA_WIDTH(DATA_WIDTH), .NUM_PR(NUM_PR), .NUM_ALU_RS(NUM_ALU_RS),
    .NUM_MUL_RS(NUM_MUL_RS), .MUL_LATENCY(MUL_LATENCY)
  ) u_rs (
    .clock, .reset, .ren_valid, .ren_op, .ren_fu, .ren_dest_tag,
    .ren_src1_tag, .ren_src2_tag, .ren_imm, .src1_value, .src1_ready,
    .src2_value, .src2_ready, .cdb_valid, .cdb_tag, .cdb_value,
    .rs_accept, .alu_issue, .alu_op, .alu_a, .alu_b, .alu_tag,
    .mul_issue, .mul_a, .mul_b, .mul_tag, .rs_busy
  );

  exec_unit #(.DATA_WIDTH(DATA_WIDTH), .NUM_PR(NUM_PR), .MUL_LATENCY(MUL_LATENCY)) u_exec (
    .clock, .reset, .alu_issue, .alu_op, .alu_a, .alu_b, .alu_tag,
    .mul_issue, .mul_a, .mul_b, .mul_tag,
    .cdb_valid, .cdb_tag, .cdb_value, .exec_busy
  );

  assign busy = ren_valid || rs_busy || exec_busy;  // Anything still in flight

endmodule

// ==== sim/tb_ooo_core.sv ====
`timescale 1ns/1ns

module tb_ooo_core import ooo_pkg::*; ();

  localparam int DATA_WIDTH      = 16;
  localparam int NUM_PR          = 32;
  localparam int NUM_ALU_RS      = 3;
  localparam int NUM_MUL_RS      = 2;
  localparam int MUL_LATENCY     = 3;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_TESTS       = 6;
  localparam int NUM_ROWS        = 40;
  localparam int RAND_ROWS       = 12;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + NUM_TESTS * RESET_CYCLES;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  op_t                   dispatch_op;
  logic [ARCH_W-1:0]     dispatch_dest;
  logic [ARCH_W-1:0]     dispatch_src1;
  logic [ARCH_W-1:0]     dispatch_src2;
  logic [IMM_W-1:0]      dispatch_imm;
  logic [ARCH_W-1:0]     arch_rd_idx;
  logic                  dispatch_ready;
  logic [DATA_WIDTH-1:0] arch_rd_value;
  logic                  arch_rd_ready;
  logic                  busy;

  // Stimulus table, one instruction per row
  op_t                   row_op   [NUM_ROWS];
  logic [ARCH_W-1:0]     row_dest [NUM_ROWS];
  logic [ARCH_W-1:0]     row_src1 [NUM_ROWS];
  logic [ARCH_W-1:0]     row_src2 [NUM_ROWS];
  logic [IMM_W-1:0]      row_imm  [NUM_ROWS];
  string                 test_name  [NUM_TESTS];
  int                    test_start [NUM_TESTS];
  int                    test_len   [NUM_TESTS];
  logic                  test_stall [NUM_TESTS];  // Test must see dispatch_ready low
  logic [DATA_WIDTH-1:0] model_regs [NUM_ARCH];

  int   row_count;
  int   test_count;
  int   error_count;
  int   check_count;
  int   seed;
  logic saw_stall;

  ooo_core #(
    .DATA_WIDTH(DATA_WIDTH), .NUM_PR(NUM_PR), .NUM_ALU_RS(NUM_ALU_RS),
    .NUM_MUL_RS(NUM_MUL_RS), .MUL_LATENCY(MUL_LATENCY)
  ) DUT (
    .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_imm, .arch_rd_idx,
    .dispatch_ready, .arch_rd_value, .arch_rd_ready, .busy
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the core did not finish the program in time");
    $display("TESTS FAILED");
    $finish;
  end

  // Sequential meaning of one instruction
  function automatic logic [DATA_WIDTH-1:0] model_op(op_t op, logic [DATA_WIDTH-1:0] a,
                                                     logic [DATA_WIDTH-1:0] b,
                                                     logic [IMM_W-1:0] imm);
    logic [DATA_WIDTH-1:0] imm_ext;
    imm_ext = {{(DATA_WIDTH-IMM_W){imm[IMM_W-1]}}, imm};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_ADDI: return a + imm_ext;
      default: return a * b;  // Low half of the product
    endcase
  endfunction

  task automatic begin_test(string name, logic stall);
    test_name[test_count]  = name;
    test_start[test_count] = row_count;
    test_len[test_count]   = 0;
    test_stall[test_count] = stall;
    test_count++;
  endtask

  task automatic add_row(op_t op, logic [ARCH_W-1:0] dest, logic [ARCH_W-1:0] src1,
                         logic [ARCH_W-1:0] src2, logic [IMM_W-1:0] imm);
    row_op[row_count]   = op;
    row_dest[row_count] = dest;
    row_src1[row_count] = src1;
    row_src2[row_count] = src2;
    row_imm[row_count]  = imm;
    row_count++;
    test_len[test_count-1]++;
  endtask

  task automatic build_tables();
    int rnd_op;
    begin_test("reset_state", 1'b0);
    begin_test("alu_ops", 1'b0);
    add_row(OP_ADDI, 3'd1, 3'd0, 3'd0, 8'hFF);  // 0xFFFF
    add_row(OP_ADDI, 3'd2, 3'd0, 3'd0, 8'h02);
    add_row(OP_ADDI, 3'd3, 3'd0, 3'd0, 8'h80);
    add_row(OP_ADD,  3'd4, 3'd1, 3'd2, 8'h00);  // Wraps to 1
    add_row(OP_SUB,  3'd5, 3'd2, 3'd1, 8'h00);
    add_row(OP_AND,  3'd6, 3'd1, 3'd3, 8'h00);
    add_row(OP_ADDI, 3'd7, 3'd3, 3'd0, 8'hFF);
    begin_test("raw_chain", 1'b0);
    add_row(OP_ADDI, 3'd1, 3'd0, 3'd0, 8'h07);
    add_row(OP_ADDI, 3'd2, 3'd0, 3'd0, 8'h09);
    add_row(OP_MUL,  3'd3, 3'd1, 3'd2, 8'h00);
    add_row(OP_ADD,  3'd4, 3'd3, 3'd1, 8'h00);
    add_row(OP_SUB,  3'd5, 3'd4, 3'd2, 8'h00);
    add_row(OP_ADDI, 3'd0, 3'd2, 3'd0, 8'h05);  // Ready just as the first MUL result is due
    add_row(OP_MUL,  3'd6, 3'd5, 3'd3, 8'h00);
    add_row(OP_AND,  3'd7, 3'd6, 3'd4, 8'h00);
    add_row(OP_ADDI, 3'd1, 3'd7, 3'd0, 8'h01);
    begin_test("waw", 1'b0);
    add_row(OP_ADDI, 3'd1, 3'd0, 3'd0, 8'd100);
    add_row(OP_ADDI, 3'd2, 3'd0, 3'd0, 8'd50);
    add_row(OP_MUL,  3'd3, 3'd1, 3'd2, 8'h00);  // Slow writer
    add_row(OP_ADD,  3'd3, 3'd1, 3'd2, 8'h00);  // Later, faster writer
    begin_test("mul_backpressure", 1'b1);
    add_row(OP_ADDI, 3'd1, 3'd0, 3'd0, 8'h03);
    add_row(OP_ADDI, 3'd2, 3'd0, 3'd0, 8'h05);
    for (int i = 0; i < 6; i++) begin
      add_row(OP_MUL, 3'd1, 3'd1, 3'd2, 8'h00);
    end
    begin_test("random", 1'b0);
    for (int i = 0; i < RAND_ROWS; i++) begin
      rnd_op = $unsigned($random(seed)) % 5;
      add_row(op_t'(3'(rnd_op)), 3'($random(seed)), 3'($random(seed)),
              3'($random(seed)), 8'($random(seed)));
    end
  endtask

  task automatic apply_reset();
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic dispatch_row(int r);
    dispatch_valid = 1'b1;
    dispatch_op    = row_op[r];
    dispatch_dest  = row_dest[r];
    dispatch_src1  = row_src1[r];
    dispatch_src2  = row_src2[r];
    dispatch_imm   = row_imm[r];
    while (!dispatch_ready) begin
      saw_stall = 1'b1;
      @(negedge clock);
    end
    @(negedge clock);
    dispatch_valid = 1'b0;
  endtask

  task automatic check_regs();
    for (int i = 0; i < NUM_ARCH; i++) begin
      arch_rd_idx = ARCH_W'(i);
      #1;  // Read port is combinational
      check_count++;
      if (arch_rd_value !== model_regs[i]) begin
        $display("mismatch at %0t ns: arch_rd_value r%0d expected %h actual %h",
                 $time, i, model_regs[i], arch_rd_value);
        error_count++;
      end
      if (arch_rd_ready !== 1'b1) begin
        $display("mismatch at %0t ns: arch_rd_ready r%0d expected 1 actual %b",
                 $time, i, arch_rd_ready);
        error_count++;
      end
      @(negedge clock);
    end
  endtask

  initial begin
    int errors_before;
    int tests_ok;
    int tests_bad;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = OP_ADD;
    dispatch_dest  = '0;
    dispatch_src1  = '0;
    dispatch_src2  = '0;
    dispatch_imm   = '0;
    arch_rd_idx    = '0;
    row_count      = 0;
    test_count     = 0;
    error_count    = 0;
    check_count    = 0;
    tests_ok       = 0;
    tests_bad      = 0;
    seed           = 82907;
    build_tables();

    for (int t = 0; t < test_count; t++) begin
      errors_before = error_count;
      saw_stall     = 1'b0;
      apply_reset();
      check_count++;
      if (dispatch_ready !== 1'b1) begin
        $display("mismatch at %0t ns: dispatch_ready expected 1 actual %b",
                 $time, dispatch_ready);
        error_count++;
      end
      check_count++;
      if (busy !== 1'b0) begin
        $display("mismatch at %0t ns: busy expected 0 actual %b", $time, busy);
        error_count++;
      end
      for (int r = test_start[t]; r < test_start[t] + test_len[t]; r++) begin
        dispatch_row(r);
      end
      while (busy) @(negedge clock);  // Watchdog bounds this wait
      for (int i = 0; i < NUM_ARCH; i++) begin
        model_regs[i] = '0;
      end
      for (int r = test_start[t]; r < test_start[t] + test_len[t]; r++) begin
        model_regs[row_dest[r]] = model_op(row_op[r], model_regs[row_src1[r]],
                                           model_regs[row_src2[r]], row_imm[r]);
      end
      check_regs();
      check_count++;
      if (test_stall[t] && !saw_stall) begin
        $display("test %s: dispatch_ready never went low under back-pressure", test_name[t]);
        error_count++;
      end
      if (error_count == errors_before) begin
        tests_ok++;
        $display("test %0d %s: ok (%0d rows)", t, test_name[t], test_len[t]);
      end else begin
        tests_bad++;
        $display("test %0d %s: %0d errors", t, test_name[t], error_count - errors_before);
      end
    end

    $display("%0d tests ok, %0d tests failed, %0d checks, %0d errors",
             tests_ok, tests_bad, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/ooo_pkg.sv
hdl/rename_stage.sv
hdl/phys_regfile.sv
hdl/reservation_station.sv
hdl/exec_unit.sv
hdl/ooo_core.sv
sim/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ooo_core -f flist.f -o tb_ooo_core
./obj_dir/tb_ooo_core > sim.log
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
